/* include/ctrl_defines.svh */
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// Instruction field widths
`define OPCODE_W  6  // Bits 31:26
`define FUNCT_W   6  // Bits 5:0

// ALU operation code seen by the ALU control block
`define ALUOP_W   4

// Step counter inside one phase
`define STEP_W    4

// Mux select widths
`define SEL_W     2  // PC, ALU source and register destination
`define DATASEL_W 3  // Register file write data

`endif

/* hdl/isaPkg.sv */
`include "ctrl_defines.svh"

package isaPkg;

  // Primary opcodes still handled by the control unit
  typedef enum logic [`OPCODE_W-1:0] {
    opRtype = 6'h00,
    opJ     = 6'h02,
    opJal   = 6'h03
  } opcode_t;

  // R-type function codes
  typedef enum logic [`FUNCT_W-1:0] {
    functSll  = 6'h00,
    functSrl  = 6'h02,
    functSra  = 6'h03,
    functSllv = 6'h04,
    functSrav = 6'h07,
    functJr   = 6'h08,
    functMfhi = 6'h10,
    functMflo = 6'h12,
    functDiv  = 6'h1A,
    functAdd  = 6'h20,
    functSub  = 6'h22,
    functAnd  = 6'h24,
    functSlt  = 6'h2A
  } funct_t;

endpackage

/* hdl/ctrlPkg.sv */
`include "ctrl_defines.svh"

package ctrlPkg;

  typedef enum logic [1:0] {resetPhase, fetch, execute} phase_t;

  // One class per distinct step table
  typedef enum logic [3:0] {
    ARITH, VARSHIFT, CONSTSHIFT, JR, MOVEHILO, JUMP, JAL, DIV, ILLEGAL
  } instrClass_t;

  // Codes understood by the ALU control block
  typedef enum logic [`ALUOP_W-1:0] {
    NOPASS_A  = 4'd0,  // Passes A through
    ADD       = 4'd1,
    SUB       = 4'd2,
    AND       = 4'd3,
    PASS_B    = 4'd4,
    SHIFT_L1  = 4'd5,  // Shift amount from shamt
    SHIFT_L2  = 4'd6,  // Shift amount from rs
    SHIFT_R   = 4'd7,
    SHIFT_RA1 = 4'd8,
    SHIFT_RA2 = 4'd9,
    SLT       = 4'd10
  } aluOp_t;

  typedef enum logic [`SEL_W-1:0] {
    pcAluResult = 2'b00, pcAluOut = 2'b01, pcJumpTarget = 2'b10, pcUnused = 2'b11
  } pcSel_t;

  typedef enum logic [`SEL_W-1:0] {srcAPc = 2'b00, srcARegA = 2'b01} srcASel_t;
  typedef enum logic [`SEL_W-1:0] {srcBRegB = 2'b00, srcBFour = 2'b01} srcBSel_t;

  typedef enum logic [`SEL_W-1:0] {dstRt = 2'b00, dstRd = 2'b01, dstRa = 2'b11} regDstSel_t;

  typedef enum logic [`DATASEL_W-1:0] {
    dataAluOut = 3'b000, dataHi = 3'b011, dataLo = 3'b100, dataPc = 3'b110
  } regDataSel_t;

endpackage

/* hdl/decodeIf.sv */
`timescale 1ns/1ps

// Decoded view of the instruction currently held in IR
interface decodeIf;
  ctrlPkg::instrClass_t instrClass;
  ctrlPkg::aluOp_t      aluOp;
  logic                 isHi;        // mfhi rather than mflo
  logic                 isJumpLink;  // Jump also writes ra

  modport producer (output instrClass, aluOp, isHi, isJumpLink);
  modport consumer (input instrClass, aluOp, isHi, isJumpLink);

endinterface

/* hdl/stepIf.sv */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

interface stepIf;
  ctrlPkg::phase_t      phase;
  logic [`STEP_W-1:0]   step;
  ctrlPkg::instrClass_t activeClass;  // Class latched at fetch step 2
  logic                 activeHi;
  logic                 lastStep;     // Final execute step of the instruction

  modport producer (output phase, step, activeClass, activeHi, lastStep);
  modport consumer (input phase, step, activeClass, activeHi, lastStep);

endinterface

/* hdl/instrDecoder.sv */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module instrDecoder (
  input  logic [`OPCODE_W-1:0] opcode,
  input  logic [`FUNCT_W-1:0]  funct,
  decodeIf.producer            decoded
);
  import isaPkg::*;
  import ctrlPkg::*;

  always_comb begin
    decoded.instrClass = ILLEGAL;  // Unsupported codes only advance the PC
    decoded.aluOp      = NOPASS_A;
    decoded.isHi       = (funct == functMfhi);
    decoded.isJumpLink = (opcode == opJal);
    case (opcode)
      opRtype: begin
        case (funct)
          functAdd, functAnd, functSub, functSlt: decoded.instrClass = ARITH;
          functSllv, functSrav:                   decoded.instrClass = VARSHIFT;
          functSll, functSra, functSrl:           decoded.instrClass = CONSTSHIFT;
          functJr:                                decoded.instrClass = JR;
          functMfhi, functMflo:                   decoded.instrClass = MOVEHILO;
          functDiv:                               decoded.instrClass = DIV;
          default:                                decoded.instrClass = ILLEGAL;
        endcase
        case (funct)
          functAdd:  decoded.aluOp = ADD;
          functAnd:  decoded.aluOp = AND;
          functSub:  decoded.aluOp = SUB;
          functSlt:  decoded.aluOp = SLT;
          functSllv: decoded.aluOp = SHIFT_L2;
          functSrav: decoded.aluOp = SHIFT_RA2;
          functSll:  decoded.aluOp = SHIFT_L1;
          functSra:  decoded.aluOp = SHIFT_RA1;
          functSrl:  decoded.aluOp = SHIFT_R;
          default:   decoded.aluOp = NOPASS_A;  // jr passes rs through
        endcase
      end
      opJ:     decoded.instrClass = JUMP;
      opJal:   decoded.instrClass = JAL;
      default: decoded.instrClass = ILLEGAL;
    endcase
  end

  // A known instruction word must always land in some class
  always_comb begin
    if (!$isunknown({opcode, funct})) begin
      assert (!$isunknown(decoded.instrClass))
        else $error("instruction class unknown for opcode %h funct %h", opcode, funct);
    end
  end

endmodule

/* hdl/stepSequencer.sv */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module stepSequencer (
  input  logic                clk,
  input  logic                reset_in,
  decodeIf.consumer           decoded,
  input  logic                divisorDone,
  stepIf.producer             seq,
  output logic                resetOut,
  output logic                pcWrite,
  output ctrlPkg::pcSel_t     pcSrc,
  output logic                irWrite,
  output ctrlPkg::srcASel_t   aluSrcA,
  output ctrlPkg::srcBSel_t   aluSrcB,
  output ctrlPkg::aluOp_t     aluOp,
  output logic                aluOutWrite,
  output logic                aWrite,
  output logic                bWrite,
  output logic                divStart,
  output logic                divReset
);
  import ctrlPkg::*;

  phase_t             phase;
  logic [`STEP_W-1:0] step;
  instrClass_t        activeClass;
  aluOp_t             activeOp;
  logic               activeHi;
  logic [`STEP_W-1:0] finalStep;
  logic               divWait;

  always_comb begin
    case (activeClass)
      VARSHIFT:      finalStep = `STEP_W'(5);  // Extra cycle for the shifter
      MOVEHILO, JAL: finalStep = `STEP_W'(1);
      default:       finalStep = `STEP_W'(4);
    endcase
  end

  assign seq.lastStep = (phase == execute) && (step == finalStep);
  assign divWait = (phase == execute) && (activeClass == DIV) &&
                   (step == `STEP_W'(2)) && !divisorDone;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      phase       <= resetPhase;
      step        <= '0;
      activeClass <= ILLEGAL;
    end else begin
      case (phase)
        resetPhase: begin
          phase <= fetch;
          step  <= '0;
        end
        fetch: begin
          if (step == `STEP_W'(2)) begin
            activeClass <= decoded.instrClass;
            step        <= '0;
            if (decoded.instrClass != JUMP && decoded.instrClass != ILLEGAL) begin
              phase <= execute;
            end
          end else begin
            step <= step + `STEP_W'(1);
          end
        end
        default: begin
          if (seq.lastStep) begin
            phase <= fetch;
            step  <= '0;
          end else if (!divWait) begin  // Holds in DIV step 2 until done
            step <= step + `STEP_W'(1);
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phase == fetch && step == `STEP_W'(2)) begin
      activeOp <= decoded.aluOp;
      activeHi <= decoded.isHi;
    end
  end

  assign seq.phase       = phase;
  assign seq.step        = step;
  assign seq.activeClass = activeClass;
  assign seq.activeHi    = activeHi;

  always_comb begin
    resetOut    = (phase == resetPhase);
    pcWrite     = 1'b0;
    pcSrc       = pcAluResult;
    irWrite     = 1'b0;
    aluSrcA     = srcAPc;
    aluSrcB     = srcBRegB;
    aluOp       = NOPASS_A;
    aluOutWrite = 1'b0;
    aWrite      = 1'b0;
    bWrite      = 1'b0;
    divStart    = 1'b0;
    divReset    = 1'b1;
    case (phase)
      fetch: begin
        aluSrcB     = srcBFour;  // PC + 4
        aluOp       = ADD;
        pcSrc       = pcAluOut;
        irWrite     = (step == '0);
        aluOutWrite = (step == '0);
        if (step == `STEP_W'(2)) begin
          pcWrite = 1'b1;
          if (decoded.instrClass inside {JUMP, JAL}) begin
            pcSrc = pcJumpTarget;
          end
        end
      end
      execute: begin
        case (activeClass)
          ARITH, VARSHIFT, DIV: begin
            aWrite = (step == '0);
            bWrite = (step == '0);
          end
          CONSTSHIFT: bWrite = (step == '0);
          JR:         aWrite = (step == '0);
          default:    ;
        endcase
        if (step != '0) begin
          case (activeClass)
            ARITH, VARSHIFT: begin
              aluSrcA = srcARegA;
              aluOp   = activeOp;
            end
            CONSTSHIFT: aluOp = activeOp;  // Shift amount comes from shamt
            JR: begin
              aluSrcA = srcARegA;
              aluOp   = activeOp;
              pcWrite = (step == `STEP_W'(2));
            end
            DIV: begin
              if (step <= `STEP_W'(3)) begin
                divStart = 1'b1;
                divReset = 1'b0;
              end
            end
            default: ;
          endcase
        end
      end
      default: ;
    endcase
  end

  pcIrExclusive: assert property (@(posedge clk) disable iff (reset_in)
    !(pcWrite && irWrite))
    else $error("pcWrite and irWrite pulsed in the same cycle");

  divStartOnlyInDiv: assert property (@(posedge clk) disable iff (reset_in)
    divStart |-> (phase == execute && activeClass == DIV))
    else $error("divStart raised outside a div instruction");

endmodule

/* hdl/writebackControl.sv */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module writebackControl (
  decodeIf.consumer            decoded,
  stepIf.consumer              seq,
  output logic                 regFileWrite,
  output ctrlPkg::regDstSel_t  regDstSel,
  output ctrlPkg::regDataSel_t regDataSel,
  output logic                 hiWrite,
  output logic                 loWrite
);
  import ctrlPkg::*;

  always_comb begin
    regFileWrite = 1'b0;
    regDstSel    = dstRt;
    regDataSel   = dataAluOut;
    hiWrite      = 1'b0;
    loWrite      = 1'b0;
    if (seq.phase == fetch && seq.step == `STEP_W'(2)) begin
      // mfhi, mflo and jal write back together with the PC update
      if (decoded.isJumpLink) begin
        regFileWrite = 1'b1;
        regDstSel    = dstRa;
        regDataSel   = dataPc;
      end else if (decoded.instrClass == MOVEHILO) begin
        regFileWrite = 1'b1;
        regDstSel    = dstRd;
        regDataSel   = decoded.isHi ? dataHi : dataLo;
      end
    end else if (seq.phase == execute) begin
      case (seq.activeClass)
        ARITH, CONSTSHIFT: begin
          regDstSel    = dstRd;
          regFileWrite = (seq.step == `STEP_W'(2));
        end
        VARSHIFT: begin
          regDstSel    = dstRd;
          regFileWrite = (seq.step == `STEP_W'(3));  // One step later for the shifter
        end
        MOVEHILO: begin
          regDstSel  = dstRd;
          regDataSel = seq.activeHi ? dataHi : dataLo;
        end
        JAL: begin
          regDstSel  = dstRa;
          regDataSel = dataPc;
        end
        DIV: begin
          hiWrite = (seq.step == `STEP_W'(3));
          loWrite = (seq.step == `STEP_W'(3));
        end
        default: ;
      endcase
    end
  end

  // Quotient and remainder land together, never on the closing step
  always_comb begin
    assert (hiWrite == loWrite)
      else $error("hiWrite and loWrite differ");
    assert (!(seq.lastStep && (regFileWrite || hiWrite)))
      else $error("register write on the last step of an instruction");
  end

endmodule

/* hdl/controlUnit.sv */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module controlUnit (
  input  logic                  clk,
  input  logic                  reset_in,
  input  logic [`OPCODE_W-1:0]  opcode,
  input  logic [`FUNCT_W-1:0]   funct,
  input  logic                  divisorDone,
  output logic                  resetOut,
  output logic                  pcWrite,
  output ctrlPkg::pcSel_t       pcSrc,
  output logic                  irWrite,
  output ctrlPkg::srcASel_t     aluSrcA,
  output ctrlPkg::srcBSel_t     aluSrcB,
  output ctrlPkg::aluOp_t       aluOp,
  output logic                  aluOutWrite,
  output logic                  aWrite,
  output logic                  bWrite,
  output logic                  divStart,
  output logic                  divReset,
  output logic                  regFileWrite,
  output ctrlPkg::regDstSel_t   regDstSel,
  output ctrlPkg::regDataSel_t  regDataSel,
  output logic                  hiWrite,
  output logic                  loWrite
);

  decodeIf decodedBus ();
  stepIf   seqBus ();

  instrDecoder instrDecoder_inst (
    .opcode  (opcode),
    .funct   (funct),
    .decoded (decodedBus.producer)
  );

  stepSequencer stepSequencer_inst (
    .clk         (clk),
    .reset_in    (reset_in),
    .decoded     (decodedBus.consumer),
    .divisorDone (divisorDone),
    .seq         (seqBus.producer),
    .resetOut    (resetOut),
    .pcWrite     (pcWrite),
    .pcSrc       (pcSrc),
    .irWrite     (irWrite),
    .aluSrcA     (aluSrcA),
    .aluSrcB     (aluSrcB),
    .aluOp       (aluOp),
    .aluOutWrite (aluOutWrite),
    .aWrite      (aWrite),
    .bWrite      (bWrite),
    .divStart    (divStart),
    .divReset    (divReset)
  );

  writebackControl writebackControl_inst (
    .decoded      (decodedBus.consumer),
    .seq          (seqBus.consumer),
    .regFileWrite (regFileWrite),
    .regDstSel    (regDstSel),
    .regDataSel   (regDataSel),
    .hiWrite      (hiWrite),
    .loWrite      (loWrite)
  );

endmodule

/* bench/ctrlChecker.sv */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module ctrlChecker (
  input  logic                 clk,
  input  logic                 reset_in,
  input  logic [`OPCODE_W-1:0] opcode,
  input  logic [`FUNCT_W-1:0]  funct,
  input  logic                 divisorDone,
  input  logic                 resetOut,
  input  logic                 pcWrite,
  input  ctrlPkg::pcSel_t      pcSrc,
  input  logic                 irWrite,
  input  ctrlPkg::srcASel_t    aluSrcA,
  input  ctrlPkg::srcBSel_t    aluSrcB,
  input  ctrlPkg::aluOp_t      aluOp,
  input  logic                 aluOutWrite,
  input  logic                 aWrite,
  input  logic                 bWrite,
  input  logic                 divStart,
  input  logic                 divReset,
  input  logic                 regFileWrite,
  input  ctrlPkg::regDstSel_t  regDstSel,
  input  ctrlPkg::regDataSel_t regDataSel,
  input  logic                 hiWrite,
  input  logic                 loWrite,
  input  int                   curTest,
  input  logic [7:0]           expCycles,
  input  logic [7:0]           expAluOp,
  input  logic [7:0]           expDst,
  input  logic [7:0]           expData,
  output int                   errorCount,
  output int                   testCount
);
  import isaPkg::*;
  import ctrlPkg::*;

  int          cyc;  // Cycles since the last irWrite
  int          testErrors;
  int          pcWrites;
  int          regWrites;
  int          hiWrites;
  bit          startSeen;
  bit          doneSeen;
  bit          clocked;
  bit          leftReset;
  logic [8:0]  enables;
  logic [14:0] selects;

  assign enables = {pcWrite, irWrite, aluOutWrite, aWrite, bWrite, divStart,
                    regFileWrite, hiWrite, loWrite};
  assign selects = {pcSrc, aluSrcA, aluSrcB, aluOp, regDstSel, regDataSel};

  function automatic bit divCode();
    return (opcode == opRtype) && (funct == functDiv);
  endfunction

  function automatic bit jrCode();
    return (opcode == opRtype) && (funct == functJr);
  endfunction

  // Divider active from execute step 1 through the HI/LO write
  function automatic bit divRunning();
    return (curTest >= 0) && divCode() && (cyc >= 4) && (hiWrites == 0);
  endfunction

  task automatic checkValue(input string what, input int got, input int want);
    if (got != want) begin
      errorCount++;
      testErrors++;
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic closeTest(input int cycles);
    checkValue("cycles between irWrite pulses", cycles, int'(expCycles));
    checkValue("pcWrite pulses", pcWrites, jrCode() ? 2 : 1);
    // Three-cycle codes are j and unsupported ones and write no register
    checkValue("regFileWrite pulses", regWrites,
               (expCycles == 8'd3 || divCode() || jrCode()) ? 0 : 1);
    checkValue("hiWrite pulses", hiWrites, divCode() ? 1 : 0);
    testCount++;
    $display("Test %0d, opcode %h funct %h: %0d cycles, %0d errors",
             curTest, opcode, funct, cycles, testErrors);
  endtask

  always @(posedge clk) begin
    if (reset_in || !leftReset) begin
      if (clocked) begin  // Phase is unknown before the first edge
        checkValue("resetOut during reset", int'(resetOut), 1);
        checkValue("divReset during reset", int'(divReset), 1);
        checkValue("enables during reset", int'(enables), 0);
        checkValue("selects during reset", int'(selects), 0);
      end
      clocked   = 1'b1;
      leftReset = !reset_in;  // One reset-phase cycle follows the release
    end else begin
      checkValue("resetOut", int'(resetOut), 0);
      checkValue("loWrite against hiWrite", int'(loWrite), int'(hiWrite));
      cyc++;
      checkValue("divStart", int'(divStart), int'(divRunning()));
      checkValue("divReset", int'(divReset), int'(!divRunning()));
      if (irWrite) begin
        if (curTest >= 0) begin
          closeTest(cyc);
        end
        cyc        = 0;
        testErrors = 0;
        pcWrites   = 0;
        regWrites  = 0;
        hiWrites   = 0;
        startSeen  = 1'b0;
        doneSeen   = 1'b0;
        checkValue("aluOutWrite at fetch", int'(aluOutWrite), 1);
        checkValue("aluOp at fetch", int'(aluOp), int'(ADD));
        checkValue("aluSrcA at fetch", int'(aluSrcA), int'(srcAPc));
        checkValue("aluSrcB at fetch", int'(aluSrcB), int'(srcBFour));
        checkValue("pcSrc at fetch", int'(pcSrc), int'(pcAluOut));
        checkValue("divStart at irWrite", int'(divStart), 0);
      end else if (curTest >= 0) begin
        if (cyc == 2) begin
          checkValue("pcWrite two cycles after irWrite", int'(pcWrite), 1);
        end
        if (pcWrite) begin
          pcWrites++;
          if (cyc == 2) begin
            checkValue("pcSrc at fetch pcWrite", int'(pcSrc),
                       int'((opcode == opJ || opcode == opJal) ? pcJumpTarget : pcAluOut));
          end else begin  // Only jr writes the PC again
            checkValue("pcSrc at jr", int'(pcSrc), int'(pcAluResult));
            checkValue("aluOp at jr", int'(aluOp), int'(expAluOp));
          end
        end
        if (regFileWrite) begin
          regWrites++;
          checkValue("regDstSel", int'(regDstSel), int'(expDst));
          checkValue("regDataSel", int'(regDataSel), int'(expData));
          checkValue("pcWrite with regFileWrite", int'(pcWrite), int'(expCycles == 8'd5));
          if (!pcWrite) begin
            checkValue("aluOp at regFileWrite", int'(aluOp), int'(expAluOp));
          end
        end
        if (divStart) begin
          startSeen = 1'b1;
          checkValue("divStart in a div", int'(divCode()), 1);
        end
        if (divisorDone) begin
          doneSeen = 1'b1;
        end
        if (hiWrite) begin
          hiWrites++;
          checkValue("divStart before hiWrite", int'(startSeen), 1);
          checkValue("divisorDone before hiWrite", int'(doneSeen), 1);
        end
      end
    end
  end

endmodule

/* bench/tbControlUnit.sv */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module tbControlUnit;
  import isaPkg::*;
  import ctrlPkg::*;

  localparam int COLS       = 7;   // Fields per test line
  localparam int MAX_TESTS  = 32;
  localparam int WAIT_LIMIT = 64;  // Cycles allowed between irWrite pulses

  logic                 clk;
  logic                 reset_in;
  logic [`OPCODE_W-1:0] opcode;
  logic [`FUNCT_W-1:0]  funct;
  logic                 divisorDone = 1'b0;
  logic                 resetOut;
  logic                 pcWrite;
  pcSel_t               pcSrc;
  logic                 irWrite;
  srcASel_t             aluSrcA;
  srcBSel_t             aluSrcB;
  aluOp_t               aluOp;
  logic                 aluOutWrite;
  logic                 aWrite;
  logic                 bWrite;
  logic                 divStart;
  logic                 divReset;
  logic                 regFileWrite;
  regDstSel_t           regDstSel;
  regDataSel_t          regDataSel;
  logic                 hiWrite;
  logic                 loWrite;

  logic [7:0] testData [0:MAX_TESTS*COLS];  // Word 0 holds the number of tests
  int         curTest;                      // -1 while no test is running
  logic [7:0] expCycles;
  logic [7:0] expAluOp;
  logic [7:0] expDst;
  logic [7:0] expData;
  int         divDelay;
  int         divCount;
  logic       divStartLast;
  integer     seed;
  int         errorCount;
  int         testCount;

  controlUnit controlUnit_inst (.*);
  ctrlChecker ctrlChecker_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Divider model raises done divDelay cycles after divStart rises
  always @(posedge clk) begin
    divStartLast <= divStart;
    if (reset_in || hiWrite) begin
      divisorDone <= 1'b0;
      divCount    <= 0;
    end else if (divStart && !divStartLast) begin
      divCount <= divDelay;
    end else if (divCount > 0) begin
      divCount <= divCount - 1;
      if (divCount == 1) begin
        divisorDone <= 1'b1;
      end
    end
  end

  task automatic waitIrWrite(output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < WAIT_LIMIT) begin
      @(posedge clk);
      seen = irWrite;  // Value of the cycle that just ended
      n++;
    end
  endtask

  initial begin
    int t;
    int nTests;
    int row;
    int delay;
    bit ok;
    reset_in  = 1'b1;
    opcode    = opRtype;
    funct     = functSll;
    curTest   = -1;
    expCycles = '0;
    expAluOp  = '0;
    expDst    = '0;
    expData   = '0;
    divDelay  = 1;
    seed      = 57;
    $readmemh("bench/controlUnit_testdata.txt", testData);
    nTests = int'(testData[0]);
    repeat (8) @(posedge clk);
    reset_in <= 1'b0;
    ok = 1'b1;
    t  = 0;
    while (ok && t < nTests) begin
      waitIrWrite(ok);
      if (ok) begin
        row   = 1 + t * COLS;
        delay = int'(testData[row + 2]);
        if (delay == 0) begin
          delay = ($random(seed) & 7) + 1;  // 1 to 8 cycles
        end
        opcode    <= testData[row][`OPCODE_W-1:0];
        funct     <= testData[row + 1][`FUNCT_W-1:0];
        divDelay  <= delay;
        // Zero marks div, whose length grows with the divider delay
        expCycles <= (testData[row + 3] == 8'h00) ? 8'(delay + 8) : testData[row + 3];
        expAluOp  <= testData[row + 4];
        expDst    <= testData[row + 5];
        expData   <= testData[row + 6];
        curTest   <= t;
        t++;
      end
    end
    if (ok) begin
      waitIrWrite(ok);  // Next fetch closes the last test
    end
    @(negedge clk);
    if (!ok) begin
      $display("Timeout: no irWrite pulse within %0d cycles, waiting to start test %0d",
               WAIT_LIMIT, t);
    end
    $display("Tests finished: %0d of %0d, errors: %0d", testCount, nTests, errorCount);
    if (ok && errorCount == 0 && testCount == nTests) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* bench/controlUnit_testdata.txt */
// First word is the test count, then per line: opcode funct divDelay cycles aluOp regDst regData
// divDelay 00 draws a random delay, cycles 00 marks div with an expected delay + 8
12
00 20 00 08 01 01 00  // add
00 24 00 08 03 01 00  // and
00 22 00 08 02 01 00  // sub
00 2a 00 08 0a 01 00  // slt
00 04 00 09 06 01 00  // sllv
00 07 00 09 09 01 00  // srav
00 00 00 08 05 01 00  // sll
00 03 00 08 08 01 00  // sra
00 02 00 08 07 01 00  // srl
00 08 00 08 00 00 00  // jr
00 10 00 05 00 01 03  // mfhi
00 12 00 05 00 01 04  // mflo
02 00 00 03 00 00 00  // j
03 00 00 05 00 03 06  // jal
00 1a 03 00 00 00 00  // div, fixed delay
00 1a 00 00 00 00 00  // div, random delay
3f 00 00 03 00 00 00  // unknown opcode
00 3f 00 03 00 00 00  // unknown funct

/* files.f */
+incdir+include
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/decodeIf.sv
hdl/stepIf.sv
hdl/instrDecoder.sv
hdl/stepSequencer.sv
hdl/writebackControl.sv
hdl/controlUnit.sv
bench/ctrlChecker.sv
bench/tbControlUnit.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tbControlUnit \
  -Mdir obj_dir -o simControlUnit
./obj_dir/simControlUnit | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  echo "run.sh: test run passed"
else
  echo "run.sh: test run failed"
  exit 1
fi
